//--- src/vrf_cfg_pkg.sv
`default_nettype none

package vrf_cfg_pkg;

  //////////////////////////////////////////////////
  // register file port
  //////////////////////////////////////////////////

  // port data word and operand width
  localparam int unsigned data_width = 32;
  // byte lanes per data word
  localparam int unsigned be_width = 4;
  // word address into the register file memory
  localparam int unsigned addr_width = 10;

  //////////////////////////////////////////////////
  // vector configuration
  //////////////////////////////////////////////////

  localparam int unsigned vl_width = 12;
  // element width code, 0 bytes, 1 halfwords, 2 words
  localparam int unsigned sew_width = 2;
  // remaining words, holds the rounded up byte count divided by the word size
  localparam int unsigned word_cnt_width = 13;

endpackage

`default_nettype wire

//--- src/vrf_op_pkg.sv
`default_nettype none

package vrf_op_pkg;

  // operation requested on the command port
  typedef enum logic [1:0] {
    OP_MOVE   = 2'd0,
    OP_BINARY = 2'd1,
    OP_FILL   = 2'd2
  } vrf_op_e;

  // sequencer states, one read and its wait per operand, then the write
  typedef enum logic [2:0] {
    IDLE   = 3'd0,
    READ_A = 3'd1,
    WAIT_A = 3'd2,
    READ_B = 3'd3,
    WAIT_B = 3'd4,
    WRITE  = 3'd5
  } vrf_state_e;

  // which register base the word address is built from
  typedef enum logic [1:0] {
    SRC_VS1 = 2'd0,
    SRC_VS2 = 2'd1,
    SRC_VD  = 2'd2
  } vrf_src_e;

endpackage

`default_nettype wire

//--- src/vrf_seq_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module vrf_seq_ctrl
  import vrf_op_pkg::*;
(
  input  wire logic     clk_i,
  input  wire logic     rst_ni,

  // command port
  input  wire logic     req_i,
  input  wire vrf_op_e  op_i,
  output logic          done_o,

  // register file handshake
  output logic          data_req_o,
  output logic          data_we_o,
  input  wire logic     data_gnt_i,
  input  wire logic     data_rvalid_i,

  // datapath steering
  input  wire logic     last_word_i,
  input  wire logic     empty_i,
  output logic          start_o,
  output vrf_src_e      src_sel_o,
  output logic          step_o,
  output logic          cap_a_o,
  output logic          cap_b_o
);

  vrf_state_e state_q;
  vrf_state_e state_d;

  // first state of every word, depends only on the operands the operation reads
  function automatic vrf_state_e first_state(input vrf_op_e op);
    vrf_state_e st;
    case (op)
      OP_BINARY: st = READ_A;
      OP_MOVE:   st = READ_B;
      OP_FILL:   st = WRITE;
      default:   st = IDLE;
    endcase
    return st;
  endfunction

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  //////////////////////////////////////////////////
  // next state and outputs
  //////////////////////////////////////////////////

  always_comb begin
    state_d    = state_q;
    done_o     = 1'b0;
    data_req_o = 1'b0;
    data_we_o  = 1'b0;
    start_o    = 1'b0;
    src_sel_o  = SRC_VD;
    step_o     = 1'b0;
    cap_a_o    = 1'b0;
    cap_b_o    = 1'b0;

    case (state_q)
      IDLE: begin
        done_o = 1'b1;
        // pointers and counter load even for an empty command
        if (req_i) begin
          start_o = 1'b1;
          if (!empty_i) begin
            state_d = first_state(op_i);
          end
        end
      end

      READ_A: begin
        data_req_o = 1'b1;
        src_sel_o  = SRC_VS1;
        if (data_gnt_i) begin
          state_d = WAIT_A;
        end
      end

      // read data shows up one cycle after the grant
      WAIT_A: begin
        if (data_rvalid_i) begin
          cap_a_o = 1'b1;
          state_d = READ_B;
        end
      end

      READ_B: begin
        data_req_o = 1'b1;
        src_sel_o  = SRC_VS2;
        if (data_gnt_i) begin
          state_d = WAIT_B;
        end
      end

      WAIT_B: begin
        if (data_rvalid_i) begin
          cap_b_o = 1'b1;
          state_d = WRITE;
        end
      end

      WRITE: begin
        data_req_o = 1'b1;
        data_we_o  = 1'b1;
        src_sel_o  = SRC_VD;
        if (data_gnt_i) begin
          step_o = 1'b1;
          if (last_word_i) begin
            state_d = IDLE;
          end else begin
            state_d = first_state(op_i);
          end
        end
      end

      default: begin
        state_d = IDLE;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- src/vrf_addr_gen.sv
`timescale 1ns/1ps
`default_nettype none

module vrf_addr_gen
  import vrf_cfg_pkg::*;
  import vrf_op_pkg::*;
(
  input  wire logic                  clk_i,
  input  wire logic                  rst_ni,
  input  wire logic                  start_i,
  input  wire logic                  step_i,
  input  wire vrf_src_e              src_sel_i,
  input  wire logic [addr_width-1:0] vs1_base_i,
  input  wire logic [addr_width-1:0] vs2_base_i,
  input  wire logic [addr_width-1:0] vd_base_i,
  output logic      [addr_width-1:0] data_addr_o
);

  // word index shared by all three registers
  logic [addr_width-1:0] offset_q;
  logic [addr_width-1:0] base;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      offset_q <= '0;
    end else if (start_i) begin
      offset_q <= '0;
    end else if (step_i) begin
      offset_q <= offset_q + 1'b1;
    end
  end

  always_comb begin
    case (src_sel_i)
      SRC_VS1: base = vs1_base_i;
      SRC_VS2: base = vs2_base_i;
      default: base = vd_base_i;
    endcase
  end

  assign data_addr_o = base + offset_q;

endmodule

`default_nettype wire

//--- src/vrf_tail_mask.sv
`timescale 1ns/1ps
`default_nettype none

module vrf_tail_mask
  import vrf_cfg_pkg::*;
(
  input  wire logic                 clk_i,
  input  wire logic                 rst_ni,
  input  wire logic                 start_i,
  input  wire logic                 step_i,
  input  wire logic [vl_width-1:0]  vl_i,
  input  wire logic [sew_width-1:0] sew_i,
  output logic                      last_word_o,
  output logic                      empty_o,
  output logic      [be_width-1:0]  data_be_o
);

  // bytes need two more bits than words, since each word holds four bytes
  logic [word_cnt_width+1:0] vl_ext;
  logic [word_cnt_width+1:0] byte_cnt;
  logic [word_cnt_width-1:0] word_cnt;
  logic [word_cnt_width-1:0] remain_q;
  logic [1:0]                tail_q;

  //////////////////////////////////////////////////
  // byte and word count of the command
  //////////////////////////////////////////////////

  assign vl_ext   = {{(word_cnt_width + 2 - vl_width){1'b0}}, vl_i};
  assign byte_cnt = vl_ext << sew_i;

  // round up when the last word is partial
  assign word_cnt = byte_cnt[word_cnt_width+1:2]
                  + {{(word_cnt_width - 1){1'b0}}, |byte_cnt[1:0]};
  assign empty_o  = (word_cnt == '0);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      remain_q <= '0;
      tail_q   <= '0;
    end else if (start_i) begin
      remain_q <= word_cnt;
      tail_q   <= byte_cnt[1:0];
    end else if (step_i) begin
      remain_q <= remain_q - 1'b1;
    end
  end

  assign last_word_o = (remain_q == {{(word_cnt_width - 1){1'b0}}, 1'b1});

  // the partial last word keeps only its low tail_q bytes
  always_comb begin
    data_be_o = {be_width{1'b1}};
    if (last_word_o && (tail_q != 2'd0)) begin
      data_be_o = ~({be_width{1'b1}} << tail_q);
    end
  end

endmodule

`default_nettype wire

//--- src/vrf_operand_regs.sv
`timescale 1ns/1ps
`default_nettype none

module vrf_operand_regs
  import vrf_cfg_pkg::*;
(
  input  wire logic                  clk_i,
  input  wire logic                  rst_ni,
  input  wire logic                  cap_a_i,
  input  wire logic                  cap_b_i,
  input  wire logic [data_width-1:0] data_rdata_i,
  output logic      [data_width-1:0] rdata_a_o,
  output logic      [data_width-1:0] rdata_b_o
);

  logic [data_width-1:0] opa_q;
  logic [data_width-1:0] opb_q;

  // operands only change on read data, so the lane result holds through write stalls
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      opa_q <= '0;
      opb_q <= '0;
    end else begin
      if (cap_a_i) begin
        opa_q <= data_rdata_i;
      end
      if (cap_b_i) begin
        opb_q <= data_rdata_i;
      end
    end
  end

  assign rdata_a_o = opa_q;
  assign rdata_b_o = opb_q;

endmodule

`default_nettype wire

//--- src/vrf_stream_top.sv
`timescale 1ns/1ps
`default_nettype none

module vrf_stream_top
  import vrf_cfg_pkg::*;
  import vrf_op_pkg::*;
(
  input  wire logic                  clk_i,
  input  wire logic                  rst_ni,

  // command port
  input  wire logic                  req_i,
  input  wire vrf_op_e               op_i,
  input  wire logic [sew_width-1:0]  sew_i,
  input  wire logic [vl_width-1:0]   vl_i,
  input  wire logic [addr_width-1:0] vs1_base_i,
  input  wire logic [addr_width-1:0] vs2_base_i,
  input  wire logic [addr_width-1:0] vd_base_i,
  output logic                       done_o,

  // register file port
  output logic                       data_req_o,
  input  wire logic                  data_gnt_i,
  output logic                       data_we_o,
  output logic      [addr_width-1:0] data_addr_o,
  output logic      [be_width-1:0]   data_be_o,
  output logic      [data_width-1:0] data_wdata_o,
  input  wire logic                  data_rvalid_i,
  input  wire logic [data_width-1:0] data_rdata_i,

  // execution lane
  output logic      [data_width-1:0] rdata_a_o,
  output logic      [data_width-1:0] rdata_b_o,
  input  wire logic [data_width-1:0] wdata_i
);

  logic     start;
  logic     step;
  logic     cap_a;
  logic     cap_b;
  logic     last_word;
  logic     empty;
  vrf_src_e src_sel;

  vrf_seq_ctrl u_ctrl (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_i         (req_i),
    .op_i          (op_i),
    .done_o        (done_o),
    .data_req_o    (data_req_o),
    .data_we_o     (data_we_o),
    .data_gnt_i    (data_gnt_i),
    .data_rvalid_i (data_rvalid_i),
    .last_word_i   (last_word),
    .empty_i       (empty),
    .start_o       (start),
    .src_sel_o     (src_sel),
    .step_o        (step),
    .cap_a_o       (cap_a),
    .cap_b_o       (cap_b)
  );

  vrf_addr_gen u_addr (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .start_i     (start),
    .step_i      (step),
    .src_sel_i   (src_sel),
    .vs1_base_i  (vs1_base_i),
    .vs2_base_i  (vs2_base_i),
    .vd_base_i   (vd_base_i),
    .data_addr_o (data_addr_o)
  );

  vrf_tail_mask u_tail (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .start_i     (start),
    .step_i      (step),
    .vl_i        (vl_i),
    .sew_i       (sew_i),
    .last_word_o (last_word),
    .empty_o     (empty),
    .data_be_o   (data_be_o)
  );

  vrf_operand_regs u_opnd (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .cap_a_i      (cap_a),
    .cap_b_i      (cap_b),
    .data_rdata_i (data_rdata_i),
    .rdata_a_o    (rdata_a_o),
    .rdata_b_o    (rdata_b_o)
  );

  // lane result goes straight to memory, it holds while the write waits
  assign data_wdata_o = wdata_i;

endmodule

`default_nettype wire

//--- verif/vrf_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module vrf_mem_model
  import vrf_cfg_pkg::*;
(
  input  wire logic                  clk_i,
  input  wire logic                  rst_ni,
  input  wire logic                  req_i,
  input  wire logic                  we_i,
  input  wire logic [addr_width-1:0] addr_i,
  input  wire logic [be_width-1:0]   be_i,
  input  wire logic [data_width-1:0] wdata_i,
  output logic                       gnt_o,
  output logic                       rvalid_o,
  output logic      [data_width-1:0] rdata_o,
  output logic      [31:0]           rd_cnt_o,
  output logic      [31:0]           wr_cnt_o,
  output logic                       hold_err_o
);

  localparam int unsigned depth = 1 << addr_width;
  localparam logic [15:0] seed  = 16'd9239;

  logic [data_width-1:0] mem [depth];
  logic [15:0]           stall_lfsr_q;
  logic                  gnt_q;

  // request seen without grant in the previous cycle
  logic                  pend_q;
  logic                  we_q;
  logic [addr_width-1:0] addr_q;
  logic [be_width-1:0]   be_q;
  logic [data_width-1:0] wdata_q;

  // galois lfsr stepped once per bit taken
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {1'b0, s[15:1]} ^ (s[0] ? 16'hb400 : 16'h0000);
  endfunction

  initial begin : fill_mem
    logic [15:0]           lfsr;
    logic [data_width-1:0] word;
    lfsr = seed;
    for (int a = 0; a < int'(depth); a++) begin
      for (int b = 0; b < int'(data_width); b++) begin
        word[b] = lfsr[0];
        lfsr    = lfsr_next(lfsr);
      end
      mem[a] = word;
    end
  end

  // grant is low whenever the stall bit of this cycle is low
  assign gnt_o = req_i & gnt_q;

  //////////////////////////////////////////////////
  // storage
  //////////////////////////////////////////////////

  always @(posedge clk_i) begin
    if (req_i && gnt_o && we_i) begin
      for (int k = 0; k < int'(be_width); k++) begin
        if (be_i[k]) begin
          mem[addr_i][8*k +: 8] <= wdata_i[8*k +: 8];
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // handshake, counters and hold check
  //////////////////////////////////////////////////

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      stall_lfsr_q <= seed;
      gnt_q        <= 1'b0;
      rvalid_o     <= 1'b0;
      rdata_o      <= '0;
      rd_cnt_o     <= '0;
      wr_cnt_o     <= '0;
      pend_q       <= 1'b0;
      we_q         <= 1'b0;
      addr_q       <= '0;
      be_q         <= '0;
      wdata_q      <= '0;
      hold_err_o   <= 1'b0;
    end else begin
      stall_lfsr_q <= lfsr_next(stall_lfsr_q);
      gnt_q        <= stall_lfsr_q[0];
      rvalid_o     <= req_i & gnt_o & ~we_i;
      if (req_i && gnt_o && !we_i) begin
        rd_cnt_o <= rd_cnt_o + 32'd1;
        rdata_o  <= mem[addr_i];
      end
      if (req_i && gnt_o && we_i) begin
        wr_cnt_o <= wr_cnt_o + 32'd1;
      end
      // a stalled request must come back unchanged
      if (pend_q) begin
        assert (req_i && we_i == we_q && addr_i == addr_q && be_i == be_q && wdata_i == wdata_q)
        else begin
          $display("mismatch held request: data_req_o %h data_we_o %h/%h data_addr_o %h/%h",
                   req_i, we_i, we_q, addr_i, addr_q);
          $display("mismatch held request: data_be_o %h/%h data_wdata_o %h/%h",
                   be_i, be_q, wdata_i, wdata_q);
          hold_err_o <= 1'b1;
        end
      end
      pend_q  <= req_i & ~gnt_o;
      we_q    <= we_i;
      addr_q  <= addr_i;
      be_q    <= be_i;
      wdata_q <= wdata_i;
    end
  end

endmodule

`default_nettype wire

//--- verif/tb_vrf_stream.sv
`timescale 1ns/1ps
`default_nettype none

module tb_vrf_stream
  import vrf_cfg_pkg::*;
  import vrf_op_pkg::*;
();

  localparam int mem_depth     = 1 << addr_width;
  localparam int timeout_cycles = 4000;

  logic                  clk_i;
  logic                  rst_ni;
  logic                  req;
  vrf_op_e               op;
  logic [sew_width-1:0]  sew;
  logic [vl_width-1:0]   vl;
  logic [addr_width-1:0] vs1_base;
  logic [addr_width-1:0] vs2_base;
  logic [addr_width-1:0] vd_base;
  logic [data_width-1:0] fill_val;
  logic                  done;
  logic                  data_req;
  logic                  data_gnt;
  logic                  data_we;
  logic [addr_width-1:0] data_addr;
  logic [be_width-1:0]   data_be;
  logic [data_width-1:0] data_wdata;
  logic                  data_rvalid;
  logic [data_width-1:0] data_rdata;
  logic [data_width-1:0] rdata_a;
  logic [data_width-1:0] rdata_b;
  logic [data_width-1:0] lane_wdata;
  logic [31:0]           rd_cnt;
  logic [31:0]           wr_cnt;
  logic                  hold_err;
  logic [data_width-1:0] exp_mem [mem_depth];

  vrf_stream_top dut0 (
    .clk_i (clk_i), .rst_ni (rst_ni), .req_i (req), .op_i (op), .sew_i (sew), .vl_i (vl),
    .vs1_base_i (vs1_base), .vs2_base_i (vs2_base), .vd_base_i (vd_base), .done_o (done),
    .data_req_o (data_req), .data_gnt_i (data_gnt), .data_we_o (data_we),
    .data_addr_o (data_addr), .data_be_o (data_be), .data_wdata_o (data_wdata),
    .data_rvalid_i (data_rvalid), .data_rdata_i (data_rdata),
    .rdata_a_o (rdata_a), .rdata_b_o (rdata_b), .wdata_i (lane_wdata)
  );

  vrf_mem_model mem0 (
    .clk_i (clk_i), .rst_ni (rst_ni), .req_i (data_req), .we_i (data_we),
    .addr_i (data_addr), .be_i (data_be), .wdata_i (data_wdata), .gnt_o (data_gnt),
    .rvalid_o (data_rvalid), .rdata_o (data_rdata), .rd_cnt_o (rd_cnt), .wr_cnt_o (wr_cnt),
    .hold_err_o (hold_err)
  );

  initial clk_i = 1'b0;
  always #20 clk_i = ~clk_i;

  // execution lane
  always_comb begin
    case (op)
      OP_BINARY: lane_wdata = rdata_a ^ rdata_b;
      OP_MOVE:   lane_wdata = rdata_b;
      default:   lane_wdata = fill_val;
    endcase
  end

  task automatic stop_with_failure();
    $display("TEST FAILED");
    $fatal(1);
  endtask

  always @(posedge hold_err) stop_with_failure();

  //////////////////////////////////////////////////
  // one command, expected image and checks
  //////////////////////////////////////////////////

  task automatic run_case(input logic [31:0] c_op, input logic [31:0] c_sew,
                          input logic [31:0] c_vl, input logic [31:0] c_vs1,
                          input logic [31:0] c_vs2, input logic [31:0] c_vd,
                          input logic [31:0] c_fill);
    int          bytes;
    int          words;
    int          tail;
    int          wait_cnt;
    logic [31:0] rd0;
    logic [31:0] wr0;
    logic [31:0] exp_rd;
    logic [31:0] res;
    logic [31:0] merged;
    logic [3:0]  be;
    logic [9:0]  ia;
    logic [9:0]  ib;
    logic [9:0]  id;
    bytes = int'(c_vl[vl_width-1:0]) << c_sew[1:0];
    words = (bytes + 3) / 4;
    tail  = bytes % 4;
    for (int i = 0; i < mem_depth; i++) begin
      exp_mem[i] = mem0.mem[i];
    end
    // word by word, so overlapping registers see earlier results
    for (int w = 0; w < words; w++) begin
      ia = c_vs1[9:0] + w[9:0];
      ib = c_vs2[9:0] + w[9:0];
      id = c_vd[9:0] + w[9:0];
      case (c_op[1:0])
        2'd1:    res = exp_mem[ia] ^ exp_mem[ib];
        2'd0:    res = exp_mem[ib];
        default: res = c_fill;
      endcase
      be = 4'hf;
      if (w == words - 1 && tail != 0) begin
        be = 4'((1 << tail) - 1);
      end
      merged = exp_mem[id];
      for (int k = 0; k < 4; k++) begin
        if (be[k]) begin
          merged[8*k +: 8] = res[8*k +: 8];
        end
      end
      exp_mem[id] = merged;
    end
    case (c_op[1:0])
      2'd1:    exp_rd = 2 * words;
      2'd0:    exp_rd = words;
      default: exp_rd = 0;
    endcase
    rd0 = rd_cnt;
    wr0 = wr_cnt;

    @(posedge clk_i);
    #2;
    op       = vrf_op_e'(c_op[1:0]);
    sew      = c_sew[sew_width-1:0];
    vl       = c_vl[vl_width-1:0];
    vs1_base = c_vs1[addr_width-1:0];
    vs2_base = c_vs2[addr_width-1:0];
    vd_base  = c_vd[addr_width-1:0];
    fill_val = c_fill;
    req      = 1'b1;
    @(posedge clk_i);
    #2;
    req = 1'b0;

    if (words == 0) begin
      repeat (4) begin
        @(negedge clk_i);
        assert (done == 1'b1 && data_req == 1'b0)
        else begin
          $display("mismatch empty command: done_o %h data_req_o %h", done, data_req);
          stop_with_failure();
        end
      end
    end else begin
      @(negedge clk_i);
      assert (done == 1'b0)
      else begin
        $display("mismatch done_o after accept: got %h expected 0", done);
        stop_with_failure();
      end
      wait_cnt = 0;
      while (done !== 1'b1) begin
        @(negedge clk_i);
        wait_cnt++;
        if (wait_cnt > timeout_cycles) begin
          $display("timeout, done_o did not return high for vd base %h", c_vd);
          stop_with_failure();
        end
      end
    end

    for (int i = 0; i < mem_depth; i++) begin
      assert (mem0.mem[i] == exp_mem[i])
      else begin
        $display("mismatch mem[%h]: got %h expected %h", i, mem0.mem[i], exp_mem[i]);
        stop_with_failure();
      end
    end
    assert (rd_cnt - rd0 == exp_rd)
    else begin
      $display("mismatch read count: got %h expected %h", rd_cnt - rd0, exp_rd);
      stop_with_failure();
    end
    assert (wr_cnt - wr0 == 32'(words))
    else begin
      $display("mismatch write count: got %h expected %h", wr_cnt - wr0, words);
      stop_with_failure();
    end
  endtask

  initial begin : main
    int          fd;
    int          n;
    int          case_cnt;
    string       line;
    logic [31:0] f_op;
    logic [31:0] f_sew;
    logic [31:0] f_vl;
    logic [31:0] f_vs1;
    logic [31:0] f_vs2;
    logic [31:0] f_vd;
    logic [31:0] f_fill;
    case_cnt = 0;
    rst_ni   = 1'b0;
    req      = 1'b0;
    op       = OP_MOVE;
    sew      = '0;
    vl       = '0;
    vs1_base = '0;
    vs2_base = '0;
    vd_base  = '0;
    fill_val = '0;
    repeat (5) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    @(negedge clk_i);
    assert (done == 1'b1 && data_req == 1'b0)
    else begin
      $display("mismatch after reset: done_o %h data_req_o %h", done, data_req);
      stop_with_failure();
    end

    fd = $fopen("verif/vrf_input.txt", "r");
    if (fd == 0) begin
      $display("could not open the case file verif/vrf_input.txt");
      stop_with_failure();
    end
    // comment lines fail the scan and are skipped
    while (!$feof(fd)) begin
      n = $fgets(line, fd);
      if (n > 0) begin
        n = $sscanf(line, "%h %h %h %h %h %h %h", f_op, f_sew, f_vl, f_vs1, f_vs2, f_vd, f_fill);
        if (n == 7) begin
          run_case(f_op, f_sew, f_vl, f_vs1, f_vs2, f_vd, f_fill);
          case_cnt++;
        end
      end
    end
    $fclose(fd);

    if (case_cnt == 0) begin
      $display("no test cases were read from the case file");
      stop_with_failure();
    end else begin
      $display("TEST OK");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- verif/vrf_input.txt
// columns in hex: op sew vl vs1_base vs2_base vd_base fill
// op 0 move, 1 binary, 2 fill; sew 0 bytes, 1 halfwords, 2 words
1 2 008 000 040 080 00000000
0 0 00b 000 100 140 00000000
2 1 005 000 000 200 deadbeef
1 2 000 000 040 300 00000000
0 1 007 000 180 1c0 00000000
1 0 021 010 050 240 00000000
2 2 010 000 000 280 a5a5c3c3
1 2 004 060 070 060 00000000
0 0 001 000 3f0 3ff 00000000
0 2 003 000 3fe 000 00000000

//--- vrf_stream_top.f
src/vrf_cfg_pkg.sv
src/vrf_op_pkg.sv
src/vrf_seq_ctrl.sv
src/vrf_addr_gen.sv
src/vrf_tail_mask.sv
src/vrf_operand_regs.sv
src/vrf_stream_top.sv
verif/vrf_mem_model.sv
verif/tb_vrf_stream.sv

//--- Makefile
# Verilator build and run for the vector register file sequencer

VERILATOR ?= verilator
TOP       ?= tb_vrf_stream
FILELIST  ?= vrf_stream_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qx "TEST OK" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
